// ==== cpu_config.svh ====
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// APB bus widths
`define CPU_ADDR_WIDTH 32
`define CPU_DATA_WIDTH 32

// First fetch address after reset
`define CPU_RESET_PC 32'h0000_0000

// Fetching this word stops the core
`define CPU_HALT_WORD 32'h0000_0000

`endif

// ==== rv_isa_pkg.sv ====
package rv_isa_pkg;

	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011, // Register ALU
		OPC_OP_IMM = 7'b0010011, // Immediate ALU
		OPC_LUI    = 7'b0110111,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_BRANCH = 7'b1100011,
		OPC_JAL    = 7'b1101111
	} opcode_e;

	// Codes are shared between ALU, branch and store size
	typedef enum logic [2:0] {
		F3_ADD_BEQ_SB = 3'b000,
		F3_BNE_SH     = 3'b001,
		F3_SLT_SW     = 3'b010,
		F3_XOR        = 3'b100,
		F3_OR         = 3'b110,
		F3_AND        = 3'b111
	} funct3_e;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		funct3_e    funct3;
		logic [4:0] rd;
		opcode_e    opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		funct3_e     funct3;
		logic [4:0]  rd;
		opcode_e     opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		funct3_e    funct3;
		logic [4:0] imm_lo;
		opcode_e    opcode;
	} s_fmt_t;

	typedef struct packed {
		logic       imm_12;
		logic [5:0] imm_10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		funct3_e    funct3;
		logic [3:0] imm_4_1;
		logic       imm_11;
		opcode_e    opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0]  rd;
		opcode_e     opcode;
	} u_fmt_t;

	typedef struct packed {
		logic       imm_20;
		logic [9:0] imm_10_1;
		logic       imm_11;
		logic [7:0] imm_19_12;
		logic [4:0] rd;
		opcode_e    opcode;
	} j_fmt_t;

	// One fetched word, seen through each encoding
	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		s_fmt_t s_fmt;
		b_fmt_t b_fmt;
		u_fmt_t u_fmt;
		j_fmt_t j_fmt;
	} instr_u;

endpackage

// ==== cpu_ctrl_pkg.sv ====
package cpu_ctrl_pkg;

	typedef enum logic [3:0] {
		S_IDLE,
		S_FETCH_SETUP,
		S_FETCH_ACCESS,
		S_DECODE,
		S_EXECUTE,
		S_MEM_SETUP,
		S_MEM_ACCESS,
		S_WRITEBACK,
		S_HALT
	} cpu_state_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT // Signed compare
	} alu_op_e;

	// Source of the register write-back value
	typedef enum logic [1:0] {
		WB_ALU,
		WB_MEM,
		WB_PC4,
		WB_IMM
	} wb_sel_e;

endpackage

// ==== ctrl_if.sv ====
`timescale 1ns/1ps

interface ctrl_if import rv_isa_pkg::*, cpu_ctrl_pkg::*; ();
	logic    load_instr;
	logic    load_pc;
	logic    pc_sel;      // 1 selects branch or jump target
	logic    load_paddr;
	logic    addr_sel;    // 1 selects data address
	logic    load_pdata;
	logic    reg_write;
	wb_sel_e wb_sel;
	alu_op_e alu_op;
	logic    alu_src_imm;
	instr_u  instr;       // Held instruction back to the FSM
	logic    cmp_eq;

	modport ctrl_mp (
		output load_instr, load_pc, pc_sel, load_paddr, addr_sel,
		output load_pdata, reg_write, wb_sel, alu_op, alu_src_imm,
		input  instr, cmp_eq
	);

	modport dp_mp (
		input  load_instr, load_pc, pc_sel, load_paddr, addr_sel,
		input  load_pdata, reg_write, wb_sel, alu_op, alu_src_imm,
		output instr, cmp_eq
	);
endinterface

// ==== alu.sv ====
`timescale 1ns/1ps

module alu import cpu_ctrl_pkg::*; (
	input  alu_op_e     op,
	input  logic [31:0] a,
	input  logic [31:0] b,
	output logic [31:0] y,
	output logic        eq
);
	logic lt;

	assign lt = $signed(a) < $signed(b);
	assign eq = (a == b); // Branch compare, independent of op

	always_comb begin
		case (op)
			ALU_ADD: y = a + b;
			ALU_SUB: y = a - b;
			ALU_AND: y = a & b;
			ALU_OR:  y = a | b;
			ALU_XOR: y = a ^ b;
			ALU_SLT: y = {31'b0, lt};
			default: y = a + b;
		endcase
	end
endmodule

// ==== regfile.sv ====
`timescale 1ns/1ps

module regfile (
	input  logic        APB_PCLK,
	input  logic        we,
	input  logic [4:0]  ra0,
	input  logic [4:0]  ra1,
	input  logic [4:0]  wa,
	input  logic [31:0] wd,
	output logic [31:0] rd0,
	output logic [31:0] rd1
);
	logic [31:0] regs [0:31];

	always_ff @(posedge APB_PCLK) begin
		if (we && wa != 5'd0) begin
			regs[wa] <= wd;
		end
	end

	// x0 reads zero whatever the array holds
	assign rd0 = (ra0 == 5'd0) ? 32'd0 : regs[ra0];
	assign rd1 = (ra1 == 5'd0) ? 32'd0 : regs[ra1];
endmodule

// ==== datapath.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module datapath import rv_isa_pkg::*, cpu_ctrl_pkg::*; (
	input  logic                       APB_PCLK,
	input  logic                       APB_PRESETn,
	ctrl_if.dp_mp                      ctrl,
	input  logic [`CPU_DATA_WIDTH-1:0] prdata,
	output logic [`CPU_ADDR_WIDTH-1:0] paddr,
	output logic [`CPU_DATA_WIDTH-1:0] pwdata,
	output logic [`CPU_ADDR_WIDTH-1:0] pc,
	output logic [3:0]                 pstrb
);
	instr_u                     instr_q;
	logic [`CPU_ADDR_WIDTH-1:0] addr_q;    // Load/store address
	logic [`CPU_DATA_WIDTH-1:0] ld_data_q;
	logic [`CPU_DATA_WIDTH-1:0] st_data;
	logic [`CPU_ADDR_WIDTH-1:0] pc_plus4;
	logic [`CPU_ADDR_WIDTH-1:0] pc_target;
	logic [31:0]                imm;
	logic [31:0]                rs1_val;
	logic [31:0]                rs2_val;
	logic [31:0]                alu_b;
	logic [31:0]                alu_y;
	logic [31:0]                wb_data;
	opcode_e                    opcode;
	funct3_e                    funct3;

	assign opcode      = instr_q.r_fmt.opcode;
	assign funct3      = instr_q.r_fmt.funct3;
	assign ctrl.instr  = instr_q;
	assign pc_plus4    = pc + 32'd4;
	assign pc_target   = pc + imm;
	assign alu_b       = ctrl.alu_src_imm ? imm : rs2_val;

	always_ff @(posedge APB_PCLK) begin
		if (!APB_PRESETn) begin
			pc <= `CPU_RESET_PC;
		end else if (ctrl.load_pc) begin
			pc <= ctrl.pc_sel ? pc_target : pc_plus4;
		end
	end

	always_ff @(posedge APB_PCLK) begin
		if (ctrl.load_instr) begin
			instr_q <= prdata;
		end
		if (ctrl.load_paddr) begin
			addr_q <= alu_y;
		end
		if (ctrl.load_pdata) begin
			pwdata <= st_data;
		end
		ld_data_q <= prdata; // Holds the word from the completing ACCESS edge
	end

	// Immediate per format
	always_comb begin
		case (opcode)
			OPC_STORE:  imm = {{20{instr_q.s_fmt.imm_hi[6]}}, instr_q.s_fmt.imm_hi,
				instr_q.s_fmt.imm_lo};
			OPC_BRANCH: imm = {{19{instr_q.b_fmt.imm_12}}, instr_q.b_fmt.imm_12,
				instr_q.b_fmt.imm_11, instr_q.b_fmt.imm_10_5, instr_q.b_fmt.imm_4_1, 1'b0};
			OPC_LUI:    imm = {instr_q.u_fmt.imm, 12'b0};
			OPC_JAL:    imm = {{11{instr_q.j_fmt.imm_20}}, instr_q.j_fmt.imm_20,
				instr_q.j_fmt.imm_19_12, instr_q.j_fmt.imm_11, instr_q.j_fmt.imm_10_1, 1'b0};
			default:    imm = {{20{instr_q.i_fmt.imm[11]}}, instr_q.i_fmt.imm};
		endcase
	end

	always_comb begin
		case (ctrl.wb_sel)
			WB_MEM:  wb_data = ld_data_q;
			WB_PC4:  wb_data = pc_plus4;
			WB_IMM:  wb_data = imm;
			default: wb_data = alu_y;
		endcase
	end

	// Store data copied to every lane, strobe picks the lane
	always_comb begin
		case (funct3)
			F3_ADD_BEQ_SB: st_data = {4{rs2_val[7:0]}};
			F3_BNE_SH:     st_data = {2{rs2_val[15:0]}};
			default:       st_data = rs2_val;
		endcase
	end

	always_comb begin
		pstrb = 4'b1111; // Reads and fetches
		if (ctrl.addr_sel && opcode == OPC_STORE) begin
			case (funct3)
				F3_ADD_BEQ_SB: pstrb = 4'b0001 << addr_q[1:0];
				F3_BNE_SH:     pstrb = 4'b0011 << {addr_q[1], 1'b0};
				default:       pstrb = 4'b1111;
			endcase
		end
	end

	assign paddr = ctrl.addr_sel ? addr_q : pc;

	regfile u_regfile (
		.APB_PCLK (APB_PCLK),
		.we       (ctrl.reg_write),
		.ra0      (instr_q.r_fmt.rs1),
		.ra1      (instr_q.r_fmt.rs2),
		.wa       (instr_q.r_fmt.rd),
		.wd       (wb_data),
		.rd0      (rs1_val),
		.rd1      (rs2_val)
	);

	alu u_alu (
		.op (ctrl.alu_op),
		.a  (rs1_val),
		.b  (alu_b),
		.y  (alu_y),
		.eq (ctrl.cmp_eq)
	);
endmodule

// ==== control_unit.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module control_unit import rv_isa_pkg::*, cpu_ctrl_pkg::*; (
	input  logic                       APB_PCLK,
	input  logic                       APB_PRESETn,
	ctrl_if.ctrl_mp                    ctrl,
	input  logic [`CPU_DATA_WIDTH-1:0] prdata,
	input  logic                       pready,
	output logic                       psel,
	output logic                       penable,
	output logic                       pwrite,
	output logic                       halted
);
	cpu_state_e state;
	cpu_state_e state_nxt;
	opcode_e    opcode;
	funct3_e    funct3;
	logic       is_mem;
	logic       taken;

	assign opcode = ctrl.instr.r_fmt.opcode;
	assign funct3 = ctrl.instr.r_fmt.funct3;
	assign is_mem = (opcode == OPC_LOAD) || (opcode == OPC_STORE);
	assign taken  = (funct3 == F3_BNE_SH) ? !ctrl.cmp_eq : ctrl.cmp_eq;

	always_ff @(posedge APB_PCLK) begin
		if (!APB_PRESETn) begin
			state <= S_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			S_IDLE:         state_nxt = S_FETCH_SETUP;
			S_FETCH_SETUP:  state_nxt = S_FETCH_ACCESS;
			S_FETCH_ACCESS: if (pready) begin
				state_nxt = (prdata == `CPU_HALT_WORD) ? S_HALT : S_DECODE;
			end
			S_DECODE:       state_nxt = S_EXECUTE;
			S_EXECUTE:      state_nxt = is_mem ? S_MEM_SETUP : S_WRITEBACK;
			S_MEM_SETUP:    state_nxt = S_MEM_ACCESS;
			S_MEM_ACCESS:   if (pready) begin
				state_nxt = S_WRITEBACK;
			end
			S_WRITEBACK:    state_nxt = S_FETCH_SETUP;
			S_HALT:         state_nxt = S_HALT; // Only reset leaves
			default:        state_nxt = S_IDLE;
		endcase
	end

	// APB control straight from state, stable across SETUP and ACCESS
	assign psel    = (state == S_FETCH_SETUP) || (state == S_FETCH_ACCESS) ||
		(state == S_MEM_SETUP) || (state == S_MEM_ACCESS);
	assign penable = (state == S_FETCH_ACCESS) || (state == S_MEM_ACCESS);
	assign pwrite  = ((state == S_MEM_SETUP) || (state == S_MEM_ACCESS)) &&
		(opcode == OPC_STORE);
	assign halted  = (state == S_HALT);

	assign ctrl.load_instr = (state == S_FETCH_ACCESS) && pready;
	assign ctrl.addr_sel   = (state == S_MEM_SETUP) || (state == S_MEM_ACCESS);
	assign ctrl.load_paddr = (state == S_EXECUTE) && is_mem;
	assign ctrl.load_pdata = (state == S_EXECUTE) && (opcode == OPC_STORE);
	assign ctrl.load_pc    = (state == S_WRITEBACK);
	assign ctrl.pc_sel     = (opcode == OPC_JAL) || ((opcode == OPC_BRANCH) && taken);

	// Register write and its source
	always_comb begin
		ctrl.reg_write = 1'b0;
		ctrl.wb_sel    = WB_ALU;
		case (opcode)
			OPC_OP, OPC_OP_IMM: ctrl.reg_write = (state == S_WRITEBACK);
			OPC_LUI: begin
				ctrl.reg_write = (state == S_WRITEBACK);
				ctrl.wb_sel    = WB_IMM;
			end
			OPC_LOAD: begin
				ctrl.reg_write = (state == S_WRITEBACK);
				ctrl.wb_sel    = WB_MEM;
			end
			OPC_JAL: begin
				ctrl.reg_write = (state == S_WRITEBACK);
				ctrl.wb_sel    = WB_PC4; // Link address
			end
			default: ctrl.reg_write = 1'b0;
		endcase
	end

	// ALU decode, held steady through EXECUTE and WRITEBACK
	always_comb begin
		ctrl.alu_op      = ALU_ADD;
		ctrl.alu_src_imm = (opcode != OPC_OP) && (opcode != OPC_BRANCH);
		if (opcode == OPC_OP || opcode == OPC_OP_IMM) begin
			case (funct3)
				F3_ADD_BEQ_SB: ctrl.alu_op = (opcode == OPC_OP && ctrl.instr.r_fmt.funct7[5]) ?
					ALU_SUB : ALU_ADD;
				F3_SLT_SW:     ctrl.alu_op = ALU_SLT;
				F3_XOR:        ctrl.alu_op = ALU_XOR;
				F3_OR:         ctrl.alu_op = ALU_OR;
				F3_AND:        ctrl.alu_op = ALU_AND;
				default:       ctrl.alu_op = ALU_ADD;
			endcase
		end else if (opcode == OPC_BRANCH) begin
			ctrl.alu_op = ALU_SUB;
		end
	end
endmodule

// ==== cpu.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu (
	input  logic                       APB_PCLK,
	input  logic                       APB_PRESETn,
	output logic [`CPU_ADDR_WIDTH-1:0] paddr,
	output logic [`CPU_DATA_WIDTH-1:0] pwdata,
	input  logic [`CPU_DATA_WIDTH-1:0] prdata,
	output logic                       psel,
	output logic                       penable,
	output logic                       pwrite,
	output logic [3:0]                 pstrb,
	input  logic                       pready,
	output logic                       halted,
	output logic [`CPU_ADDR_WIDTH-1:0] pc
);
	ctrl_if ctrl0 ();

	control_unit u_control_unit (
		.APB_PCLK    (APB_PCLK),
		.APB_PRESETn (APB_PRESETn),
		.ctrl        (ctrl0.ctrl_mp),
		.prdata      (prdata),
		.pready      (pready),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.halted      (halted)
	);

	datapath u_datapath (
		.APB_PCLK    (APB_PCLK),
		.APB_PRESETn (APB_PRESETn),
		.ctrl        (ctrl0.dp_mp),
		.prdata      (prdata),
		.paddr       (paddr),
		.pwdata      (pwdata),
		.pc          (pc),
		.pstrb       (pstrb)
	);
endmodule

// ==== tb_apb_mem.sv ====
`timescale 1ns/1ps

module tb_apb_mem (
	input  logic        APB_PCLK,
	input  logic        APB_PRESETn,
	input  logic [31:0] paddr,
	input  logic [31:0] pwdata,
	input  logic [3:0]  pstrb,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	output logic [31:0] prdata,
	output logic        pready
);
	logic [31:0] mem [0:1023]; // 4 KiB, word addressed
	logic [31:0] log_addr [$];
	logic        log_write [$];
	logic [31:0] log_data [$];
	logic [3:0]  log_strb [$];
	int          wait_cnt;
	logic [31:0] word;

	initial begin
		prdata = 32'd0;
		pready = 1'b0;
	end

	always @(posedge APB_PCLK) begin
		if (APB_PRESETn !== 1'b1) begin
			pready <= 1'b0;
			wait_cnt = 0;
		end else if (psel === 1'b1 && penable !== 1'b1) begin
			wait_cnt = $urandom % 4; // SETUP picks the wait states
			pready <= (wait_cnt == 0);
			prdata <= mem[paddr[11:2]];
		end else if (psel === 1'b1 && penable === 1'b1) begin
			if (pready) begin
				if (pwrite) begin
					word = mem[paddr[11:2]];
					for (int b = 0; b < 4; b++) begin
						if (pstrb[b]) begin
							word[8*b +: 8] = pwdata[8*b +: 8];
						end
					end
					mem[paddr[11:2]] = word;
				end
				log_addr.push_back(paddr);
				log_write.push_back(pwrite);
				log_data.push_back(pwrite ? pwdata : prdata);
				log_strb.push_back(pstrb);
				pready <= 1'b0;
			end else begin
				wait_cnt = wait_cnt - 1;
				pready <= (wait_cnt == 0);
			end
		end
	end
endmodule

// ==== tb_cpu.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module tb_cpu import rv_isa_pkg::*; ();
	localparam int DATA_WORD = 512; // 0x800
	localparam int BODY_LEN  = 120;

	logic        APB_PCLK;
	logic        APB_PRESETn;
	logic [31:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [3:0]  pstrb;
	logic        pready;
	logic        halted;
	logic [31:0] pc;

	logic [31:0] prog [$];
	logic [31:0] ref_mem [0:1023];
	int          exp_kind [$]; // 0 fetch, 1 load, 2 store
	logic [31:0] exp_addr [$];
	logic        exp_write [$];
	logic [31:0] exp_data [$];
	logic [3:0]  exp_strb [$];
	logic [31:0] model_pc;
	int          errs [1:6];
	logic        in_xfer;
	logic [31:0] held_addr;
	logic [31:0] held_wdata;
	logic        held_write;
	logic [3:0]  held_strb;
	int          post_halt_xfers;

	cpu dut0 (
		.APB_PCLK    (APB_PCLK),
		.APB_PRESETn (APB_PRESETn),
		.paddr       (paddr),
		.pwdata      (pwdata),
		.prdata      (prdata),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.pstrb       (pstrb),
		.pready      (pready),
		.halted      (halted),
		.pc          (pc)
	);

	tb_apb_mem mem0 (
		.APB_PCLK    (APB_PCLK),
		.APB_PRESETn (APB_PRESETn),
		.paddr       (paddr),
		.pwdata      (pwdata),
		.pstrb       (pstrb),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.prdata      (prdata),
		.pready      (pready)
	);

	initial begin
		APB_PCLK = 1'b0;
		forever #20 APB_PCLK = ~APB_PCLK;
	end

	task automatic check_word(input int beh, input string name, input logic [31:0] exp,
		input logic [31:0] act);
		assert (exp === act) else begin
			$display("MISMATCH %s expected %h actual %h", name, exp, act);
			errs[beh]++;
		end
	endtask

	function automatic logic [31:0] lane_mask(input logic [3:0] s);
		return {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
	endfunction

	function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [2:0] f3);
		return {imm[11:5], rs2, 5'd8, f3, imm[4:0], OPC_STORE}; // Base is always x8
	endfunction

	function automatic logic [2:0] pick_f3();
		logic [2:0] f3s [5] = '{3'b000, 3'b010, 3'b100, 3'b110, 3'b111};
		return f3s[$urandom % 5];
	endfunction

	// Registers x0..x7 carry random values, x8 holds the data base
	task automatic gen_program();
		int kind;
		int sz;
		logic [11:0] off;
		logic [2:0]  f3;
		logic [4:0]  rs1;
		for (int r = 1; r < 8; r++) begin
			prog.push_back({12'($urandom), 5'd0, 3'b000, 5'(r), OPC_OP_IMM});
		end
		prog.push_back({12'h400, 5'd0, 3'b000, 5'd8, OPC_OP_IMM});
		prog.push_back({7'd0, 5'd8, 5'd8, 3'b000, 5'd8, OPC_OP});
		for (int i = 0; i < BODY_LEN; i++) begin
			kind = $urandom % 10;
			if (kind >= 8 && i >= BODY_LEN - 4) begin
				kind = 3; // No forward jump past the epilogue
			end
			f3  = pick_f3();
			rs1 = 5'($urandom % 8);
			case (kind)
				0, 1, 2: prog.push_back({1'b0, (f3 == 3'b000) ? 1'($urandom) : 1'b0, 5'd0,
					5'($urandom % 8), rs1, f3, 5'($urandom % 8), OPC_OP});
				3, 4: prog.push_back({12'($urandom), rs1, f3, 5'($urandom % 8), OPC_OP_IMM});
				5: prog.push_back({20'($urandom), 5'($urandom % 8), OPC_LUI});
				6: prog.push_back({12'(($urandom % 56) * 4), 5'd8, 3'b010, 5'($urandom % 8),
					OPC_LOAD});
				7: begin
					sz  = $urandom % 3;
					off = 12'(($urandom % 224) & ~((1 << sz) - 1)); // Size aligned
					prog.push_back(enc_s(off, 5'($urandom % 8), 3'(sz)));
				end
				8: prog.push_back(enc_b(13'((1 + $urandom % 4) * 4),
					($urandom % 2) ? rs1 : 5'($urandom % 8), rs1, 3'($urandom % 2)));
				default: prog.push_back(enc_j(21'((1 + $urandom % 4) * 4), 5'($urandom % 8)));
			endcase
		end
		for (int r = 0; r < 8; r++) begin
			prog.push_back(enc_s(12'(224 + 4 * r), 5'(r), 3'b010));
		end
		prog.push_back(`CPU_HALT_WORD);
	endtask

	function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic sub,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'b000:  return sub ? a - b : a + b;
			3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'b100:  return a ^ b;
			3'b110:  return a | b;
			default: return a & b;
		endcase
	endfunction

	task automatic push_exp(input int kind, input logic [31:0] a, input logic wr,
		input logic [31:0] d, input logic [3:0] s);
		exp_kind.push_back(kind);
		exp_addr.push_back(a);
		exp_write.push_back(wr);
		exp_data.push_back(d);
		exp_strb.push_back(s);
	endtask

	// Instruction-set model over its own registers and memory
	task automatic run_model();
		logic [31:0] regs [0:31];
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		logic [31:0] addr;
		logic [31:0] sd;
		logic [31:0] nxt;
		logic [31:0] imm_i;
		logic [3:0]  st;
		logic        wr;
		instr_u      iw;
		int          steps;
		int          nb;
		for (int r = 0; r < 32; r++) begin
			regs[r] = 32'd0;
		end
		model_pc = `CPU_RESET_PC;
		steps = 0;
		while (1) begin
			w  = ref_mem[model_pc[11:2]];
			iw = w;
			push_exp(0, model_pc, 1'b0, w, 4'hf);
			if (w == `CPU_HALT_WORD) break;
			steps++;
			if (steps > 10000) begin
				$display("Reference model did not reach the halt word");
				errs[2]++;
				break;
			end
			a     = regs[iw.r_fmt.rs1];
			b     = regs[iw.r_fmt.rs2];
			imm_i = {{20{w[31]}}, w[31:20]};
			nxt   = model_pc + 32'd4;
			wr    = 1'b1;
			res   = 32'd0;
			case (w[6:0])
				OPC_OP:     res = alu_ref(w[14:12], w[30], a, b);
				OPC_OP_IMM: res = alu_ref(w[14:12], 1'b0, a, imm_i);
				OPC_LUI:    res = {w[31:12], 12'b0};
				OPC_LOAD: begin
					addr = a + imm_i;
					res  = ref_mem[addr[11:2]];
					push_exp(1, addr, 1'b0, res, 4'hf);
				end
				OPC_STORE: begin
					wr   = 1'b0;
					addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
					nb   = 1 << w[13:12]; // 1, 2 or 4 bytes
					sd   = b << (8 * addr[1:0]);
					for (int k = 0; k < 4; k++) begin
						st[k] = (k >= addr[1:0]) && (k < addr[1:0] + nb);
					end
					push_exp(2, addr, 1'b1, sd, st);
					ref_mem[addr[11:2]] = (ref_mem[addr[11:2]] & ~lane_mask(st)) |
						(sd & lane_mask(st));
				end
				OPC_BRANCH: begin
					wr = 1'b0;
					if ((a == b) != w[12]) begin // funct3 bit 0 selects BNE
						nxt = model_pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
					end
				end
				default: begin
					res = model_pc + 32'd4; // JAL link
					nxt = model_pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
				end
			endcase
			if (wr && iw.r_fmt.rd != 5'd0) begin
				regs[iw.r_fmt.rd] = res;
			end
			model_pc = nxt;
		end
	endtask

	// APB protocol monitor, sampled on the rising edge
	always @(posedge APB_PCLK) begin
		if (APB_PRESETn !== 1'b1) begin
			in_xfer = 1'b0;
		end else begin
			if (halted === 1'b1 && psel === 1'b1) begin
				post_halt_xfers++;
			end
			assert (!(penable === 1'b1 && psel !== 1'b1)) else begin
				$display("Protocol error: penable high without psel");
				errs[5]++;
			end
			if (psel === 1'b1 && penable !== 1'b1) begin
				assert (!in_xfer) else begin
					$display("Protocol error: new SETUP before the transfer completed");
					errs[5]++;
				end
				in_xfer    = 1'b1;
				held_addr  = paddr;
				held_wdata = pwdata;
				held_write = pwrite;
				held_strb  = pstrb;
			end else if (psel === 1'b1 && penable === 1'b1) begin
				assert (in_xfer) else begin
					$display("Protocol error: ACCESS without a preceding SETUP");
					errs[5]++;
				end
				check_word(5, "paddr", held_addr, paddr);
				check_word(5, "pwdata", held_wdata, pwdata);
				check_word(5, "pwrite", 32'(held_write), 32'(pwrite));
				check_word(5, "pstrb", 32'(held_strb), 32'(pstrb));
				if (pready === 1'b1) begin
					in_xfer = 1'b0;
				end
			end else begin
				assert (!in_xfer) else begin
					$display("Protocol error: psel dropped before pready");
					errs[5]++;
				end
			end
		end
	end

	task automatic compare_log();
		int n;
		int beh;
		n = (exp_kind.size() < mem0.log_addr.size()) ? exp_kind.size() : mem0.log_addr.size();
		assert (exp_kind.size() == mem0.log_addr.size()) else begin
			$display("Transfer count differs, expected %0d but saw %0d",
				exp_kind.size(), mem0.log_addr.size());
			errs[2]++;
		end
		for (int i = 0; i < n; i++) begin
			beh = (exp_kind[i] == 0) ? 2 : 4;
			check_word(beh, "paddr", exp_addr[i], mem0.log_addr[i]);
			check_word(beh, "pwrite", 32'(exp_write[i]), 32'(mem0.log_write[i]));
			if (exp_kind[i] == 1) begin
				check_word(4, "prdata", exp_data[i], mem0.log_data[i]);
			end else if (exp_kind[i] == 2) begin
				check_word(4, "pstrb", 32'(exp_strb[i]), 32'(mem0.log_strb[i]));
				check_word(3, "pwdata", exp_data[i] & lane_mask(exp_strb[i]),
					mem0.log_data[i] & lane_mask(exp_strb[i]));
			end
		end
	endtask

	initial begin
		int          cyc;
		int          npass;
		int          nfail;
		int          log_len;
		logic [31:0] fill;
		string       titles [1:6];
		titles = '{"reset", "fetch order", "ALU write-back", "loads and stores",
			"APB protocol", "halt"};
		APB_PRESETn     = 1'b0;
		in_xfer         = 1'b0;
		post_halt_xfers = 0;
		for (int k = 1; k <= 6; k++) begin
			errs[k] = 0;
		end
		void'($urandom(32'h0bfd_5ce5));
		gen_program();
		for (int i = 0; i < 1024; i++) begin
			fill = (32'(i) * 32'h9E37_79B9) ^ 32'hA5A5_0000;
			if (i < prog.size()) begin
				fill = prog[i];
			end else if (i >= DATA_WORD && i < DATA_WORD + 64) begin
				fill = $urandom;
			end
			ref_mem[i] = fill;
			mem0.mem[i] = fill;
		end
		run_model();

		for (int i = 0; i < 4; i++) begin
			@(posedge APB_PCLK);
			if (i == 3) begin
				APB_PRESETn <= 1'b1;
			end
			@(negedge APB_PCLK);
			check_word(1, "psel", 32'd0, 32'(psel));
			check_word(1, "penable", 32'd0, 32'(penable));
			check_word(1, "halted", 32'd0, 32'(halted));
		end

		cyc = 0;
		while (halted !== 1'b1 && cyc < 20000) begin
			@(negedge APB_PCLK);
			cyc++;
		end
		if (halted !== 1'b1) begin
			$display("Timeout waiting for halted to rise after 20000 cycles");
			errs[6]++;
		end else begin
			log_len = mem0.log_addr.size();
			repeat (50) @(negedge APB_PCLK);

			if (mem0.log_addr.size() > 0) begin
				check_word(1, "paddr", `CPU_RESET_PC, mem0.log_addr[0]);
				check_word(1, "pwrite", 32'd0, 32'(mem0.log_write[0]));
				check_word(6, "prdata", `CPU_HALT_WORD, mem0.log_data[log_len - 1]);
			end else begin
				$display("No APB transfer was seen");
				errs[1]++;
			end
			compare_log();
			for (int i = DATA_WORD; i < DATA_WORD + 64; i++) begin
				check_word(4, "mem", ref_mem[i], mem0.mem[i]);
			end
			assert (post_halt_xfers == 0 && mem0.log_addr.size() == log_len) else begin
				$display("A transfer started after the core halted");
				errs[6]++;
			end
			check_word(6, "halted", 32'd1, 32'(halted));
			check_word(6, "pc", model_pc, pc);
		end

		npass = 0;
		nfail = 0;
		for (int k = 1; k <= 6; k++) begin
			$display("Test %0d %s: %s (%0d errors)", k, titles[k],
				(errs[k] == 0) ? "PASS" : "FAIL", errs[k]);
			if (errs[k] == 0) begin
				npass++;
			end else begin
				nfail++;
			end
		end
		$display("Tests passed: %0d, failed: %0d", npass, nfail);
		if (nfail == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end
endmodule

// ==== vlog.f ====
+incdir+.
rv_isa_pkg.sv
cpu_ctrl_pkg.sv
ctrl_if.sv
alu.sv
regfile.sv
datapath.sv
control_unit.sv
cpu.sv
tb_apb_mem.sv
tb_cpu.sv

// ==== Bender.yml ====
package:
  name: rv32_apb_cpu

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - rv_isa_pkg.sv
      - cpu_ctrl_pkg.sv
      - ctrl_if.sv
      - alu.sv
      - regfile.sv
      - datapath.sv
      - control_unit.sv
      - cpu.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_apb_mem.sv
      - tb_cpu.sv
